//--- tcb_consts.svh
/* bus widths and map sizes shared by every file; TCB_DLY is fixed at one,
   the RTL pipeline does not follow other values */
`ifndef TCB_CONSTS_SVH
`define TCB_CONSTS_SVH

////////////////////////////////////////////////////////////
// bus geometry
////////////////////////////////////////////////////////////

// address width in bits
`define TCB_ADR_W 16

// data width in bits
`define TCB_DAT_W 32

// one enable per data byte
`define TCB_BEN_W (`TCB_DAT_W/8)

// request to response delay in cycles
`define TCB_DLY 1

////////////////////////////////////////////////////////////
// interconnect and subordinates
////////////////////////////////////////////////////////////

// number of subordinate ports
`define TCB_SPN 2

// memory size in words
`define TCB_MEM_DEPTH 1024

// value returned by the identity register
`define TCB_REGS_ID 32'h7cb0_0001

`endif

//--- tcb_pkg.sv
/* word types of a single TCB transfer; widths come from tcb_consts.svh
   and the select width follows the subordinate count */
`default_nettype none

`include "tcb_consts.svh"

package tcb_pkg;

  ////////////////////////////////////////////////////////////
  // request command fields
  ////////////////////////////////////////////////////////////

  // byte address, always word aligned here
  typedef logic [`TCB_ADR_W-1:0] adr_t;

  // byte enables, bit n covers data bits 8n+7:8n
  typedef logic [`TCB_BEN_W-1:0] ben_t;

  ////////////////////////////////////////////////////////////
  // data words
  ////////////////////////////////////////////////////////////

  // write data in the request and read data in the response
  typedef logic [`TCB_DAT_W-1:0] dat_t;

  ////////////////////////////////////////////////////////////
  // routing
  ////////////////////////////////////////////////////////////

  // subordinate index from the decoder
  // width is at least one bit even for a single subordinate
  typedef logic [$clog2(`TCB_SPN)-1:0] sel_t;

endpackage: tcb_pkg

`default_nettype wire

//--- tcb_map_pkg.sv
/* address map of the interconnect; patterns must not overlap,
   the decoder gives the lower index priority without checking */
`default_nettype none

`include "tcb_consts.svh"

package tcb_map_pkg;

  // one address word, seen whole or split into fields
  typedef union packed {
    tcb_pkg::adr_t raw;
    struct packed {
      logic [3:0] page;  // 4 KiB page
      logic [9:0] idx;   // word index inside the page
      logic [1:0] off;   // byte offset, unused
    } fld;
  } adr_u;

  ////////////////////////////////////////////////////////////
  // subordinate indices
  ////////////////////////////////////////////////////////////

  localparam tcb_pkg::sel_t SEL_MEM  = 'd0;
  localparam tcb_pkg::sel_t SEL_REGS = 'd1;

  // wildcard patterns, x bits match anything
  // memory: page 0, 0x0000 to 0x0fff
  // registers: page 1, word index 0 to 3, 0x1000 to 0x100f
  localparam tcb_pkg::adr_t DAM [0:`TCB_SPN-1] = '{
    16'b0000_xxxx_xxxx_xxxx,
    16'b0001_0000_0000_xxxx
  };

endpackage: tcb_map_pkg

`default_nettype wire

//--- tcb_lib_decoder.sv
/* combinational address decoder against tcb_map_pkg::DAM;
   sel is zero when hit is low */
`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_lib_decoder #(
  // number of subordinate ports
  parameter int unsigned SPN = `TCB_SPN
)(
  input  tcb_pkg::adr_t adr,
  output tcb_pkg::sel_t sel,
  output logic          hit
);

  ////////////////////////////////////////////////////////////
  // pattern match
  ////////////////////////////////////////////////////////////

  // one match flag per map entry
  logic [SPN-1:0] mch;

  generate
    for (genvar i = 0; i < SPN; i++) begin: gen_mch
      // wildcard compare, x bits in the pattern are ignored
      assign mch[i] = (adr ==? tcb_map_pkg::DAM[i]);
    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // priority encode
  ////////////////////////////////////////////////////////////

  // scan from the top so the lowest matching index is left last
  always_comb begin
    sel = '0;
    hit = 1'b0;
    for (int i = SPN-1; i >= 0; i--) begin
      if (mch[i]) begin
        sel = tcb_pkg::sel_t'(i);
        hit = 1'b1;
      end
    end
  end

endmodule: tcb_lib_decoder

`default_nettype wire

//--- tcb_lib_demultiplexer.sv
/* one manager to two subordinates with a one cycle response;
   subordinates never stall and must answer exactly one cycle later */
`timescale 1ns/1ps
`default_nettype none

module tcb_lib_demultiplexer (
  input  wire           clk,
  input  wire           rst_n,
  // request from the manager and the decoder
  input  wire           vld,
  input  tcb_pkg::sel_t sel,
  input  wire           hit,
  // request valid per subordinate
  output logic          mem_vld,
  output logic          regs_vld,
  // responses from the subordinates
  input  wire           mem_rsp_vld,
  input  tcb_pkg::dat_t mem_rdt,
  input  wire           regs_rsp_vld,
  input  tcb_pkg::dat_t regs_rdt,
  input  wire           regs_err,
  // combined response to the manager
  output logic          rsp_vld,
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  ////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////

  // only the addressed subordinate sees the transfer
  assign mem_vld  = vld & hit & (sel == tcb_map_pkg::SEL_MEM);
  assign regs_vld = vld & hit & (sel == tcb_map_pkg::SEL_REGS);

  // select and hit delayed to the response cycle
  tcb_pkg::sel_t sel_q;
  logic          hit_q;
  // decode miss, answered by the demultiplexer itself
  logic          mis_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sel_q <= '0;
      hit_q <= 1'b0;
      mis_q <= 1'b0;
    end else begin
      // route only changes with a new transfer
      if (vld) begin
        sel_q <= sel;
        hit_q <= hit;
      end
      mis_q <= vld & ~hit;
    end
  end

  ////////////////////////////////////////////////////////////
  // response side
  ////////////////////////////////////////////////////////////

  always_comb begin
    rsp_vld = mis_q;
    rdt     = '0;
    err     = mis_q;
    if (hit_q) begin
      if (sel_q == tcb_map_pkg::SEL_REGS) begin
        rsp_vld = regs_rsp_vld;
        rdt     = regs_rdt;
        err     = regs_rsp_vld & regs_err;
      end else begin
        rsp_vld = mem_rsp_vld;
        rdt     = mem_rdt;
      end
    end
  end

endmodule: tcb_lib_demultiplexer

`default_nettype wire

//--- tcb_mem.sv
/* word memory subordinate, one cycle read latency, no error response;
   contents are undefined after power up, reset does not clear them */
`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_mem #(
  // size in words, at most 1024 for one page
  parameter int unsigned DEPTH = `TCB_MEM_DEPTH
)(
  input  wire           clk,
  input  wire           rst_n,
  // request
  input  wire           vld,
  input  wire           wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // response
  output logic          rsp_vld,
  output tcb_pkg::dat_t rdt
);

  localparam int unsigned AW = $clog2(DEPTH);

  ////////////////////////////////////////////////////////////
  // address
  ////////////////////////////////////////////////////////////

  tcb_map_pkg::adr_u adr_u;
  logic [AW-1:0]     idx;

  assign adr_u = adr;
  // page bits are already checked by the decoder
  assign idx   = adr_u.fld.idx[AW-1:0];

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  tcb_pkg::dat_t mem [0:DEPTH-1];

  // byte lane write
  always_ff @(posedge clk) begin
    if (vld && wen) begin
      for (int b = 0; b < `TCB_BEN_W; b++) begin
        if (ben[b]) begin
          mem[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  // read data, zero for a write
  always_ff @(posedge clk) begin
    if (vld) begin
      rdt <= wen ? '0 : mem[idx];
    end
  end

  // response valid follows the request by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= vld;
    end
  end

endmodule: tcb_mem

`default_nettype wire

//--- tcb_regs.sv
/* four word register bank; word 0 is a read-only identity, a write
   to it is dropped and answered with err, words 1 to 3 are scratch */
`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_regs (
  input  wire           clk,
  input  wire           rst_n,
  // request
  input  wire           vld,
  input  wire           wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // response
  output logic          rsp_vld,
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  ////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////

  tcb_map_pkg::adr_u adr_u;
  logic [1:0]        idx;
  logic              id_wr;

  assign adr_u = adr;
  // upper index bits are zero for every decoded access
  assign idx   = adr_u.fld.idx[1:0];
  // illegal write to the identity word
  assign id_wr = vld & wen & (idx == 2'd0);

  ////////////////////////////////////////////////////////////
  // scratch registers
  ////////////////////////////////////////////////////////////

  // entry n holds register n+1
  tcb_pkg::dat_t scr [0:2];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < 3; r++) begin
        scr[r] <= '0;
      end
    end else if (vld && wen && (idx != 2'd0)) begin
      for (int b = 0; b < `TCB_BEN_W; b++) begin
        if (ben[b]) begin
          scr[idx-2'd1][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // response
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
      err     <= 1'b0;
    end else begin
      rsp_vld <= vld;
      err     <= id_wr;
    end
  end

  // read mux, writes return zero
  always_ff @(posedge clk) begin
    if (vld) begin
      if (wen) begin
        rdt <= '0;
      end else if (idx == 2'd0) begin
        rdt <= `TCB_REGS_ID;
      end else begin
        rdt <= scr[idx-2'd1];
      end
    end
  end

endmodule: tcb_regs

`default_nettype wire

//--- tcb_lib_interconnect.sv
/* single manager TCB interconnect with memory and register bank;
   every request is answered one cycle later, unmapped ones with err */
`timescale 1ns/1ps
`default_nettype none

module tcb_lib_interconnect (
  input  wire           clk,
  input  wire           rst_n,
  // manager request
  input  wire           vld,
  input  wire           wen,
  input  tcb_pkg::adr_t adr,
  input  tcb_pkg::ben_t ben,
  input  tcb_pkg::dat_t wdt,
  // manager response
  output logic          rsp_vld,
  output tcb_pkg::dat_t rdt,
  output logic          err
);

  ////////////////////////////////////////////////////////////
  // internal wires
  ////////////////////////////////////////////////////////////

  tcb_pkg::sel_t sel;
  logic          hit;

  logic          mem_vld;
  logic          mem_rsp_vld;
  tcb_pkg::dat_t mem_rdt;

  logic          regs_vld;
  logic          regs_rsp_vld;
  tcb_pkg::dat_t regs_rdt;
  logic          regs_err;

  ////////////////////////////////////////////////////////////
  // instances
  ////////////////////////////////////////////////////////////

  tcb_lib_decoder dec (
    .adr (adr),
    .sel (sel),
    .hit (hit)
  );

  tcb_lib_demultiplexer dmx (
    .clk          (clk),
    .rst_n        (rst_n),
    .vld          (vld),
    .sel          (sel),
    .hit          (hit),
    .mem_vld      (mem_vld),
    .regs_vld     (regs_vld),
    .mem_rsp_vld  (mem_rsp_vld),
    .mem_rdt      (mem_rdt),
    .regs_rsp_vld (regs_rsp_vld),
    .regs_rdt     (regs_rdt),
    .regs_err     (regs_err),
    .rsp_vld      (rsp_vld),
    .rdt          (rdt),
    .err          (err)
  );

  // shared request fields go straight to both subordinates
  tcb_mem mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (mem_vld),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .rsp_vld (mem_rsp_vld),
    .rdt     (mem_rdt)
  );

  tcb_regs regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (regs_vld),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .rsp_vld (regs_rsp_vld),
    .rdt     (regs_rdt),
    .err     (regs_err)
  );

endmodule: tcb_lib_interconnect

`default_nettype wire

//--- tcb_lib_interconnect_tb.sv
/* testbench for tcb_lib_interconnect; memory words are read only after
   a full write, since the memory contents are not reset */
`timescale 1ns/1ps
`default_nettype none

`include "tcb_consts.svh"

module tcb_lib_interconnect_tb;

  localparam int CLK_PERIOD = 20;
  // requests per test
  localparam int N_MEM  = 16;
  localparam int N_MISS = 8;
  localparam int N_B2B  = 8;
  localparam int N_PRI  = 4;
  localparam int TOTAL_REQ = 3*N_MEM + 3 + 12 + (N_MISS+4) + 4*N_B2B + 2*N_PRI;
  // reset, drains between tests and slack
  localparam int WATCHDOG_CYC = TOTAL_REQ + 100;

  logic          clk;
  logic          rst_n;
  logic          vld;
  logic          wen;
  tcb_pkg::adr_t adr;
  tcb_pkg::ben_t ben;
  tcb_pkg::dat_t wdt;
  logic          rsp_vld;
  tcb_pkg::dat_t rdt;
  logic          err;

  // reference model state
  tcb_pkg::dat_t ref_mem [0:`TCB_MEM_DEPTH-1];
  tcb_pkg::dat_t ref_regs [1:3];
  tcb_pkg::dat_t exp_rdt_q [$];
  logic          exp_err_q [$];
  tcb_pkg::adr_t mem_adrs [$];

  int    seed = 32'h104e;
  int    errors = 0;
  int    lost_rsp = 0;
  int    checks = 0;
  int    tests = 0;
  int    failed = 0;
  int    err_at_start;
  string cur_test;

  tcb_lib_interconnect UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld     (vld),
    .wen     (wen),
    .adr     (adr),
    .ben     (ben),
    .wdt     (wdt),
    .rsp_vld (rsp_vld),
    .rdt     (rdt),
    .err     (err)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // model helpers
  ////////////////////////////////////////////////////////////

  function automatic tcb_pkg::dat_t merge_bytes(input tcb_pkg::dat_t old_w,
                                                input tcb_pkg::dat_t new_w,
                                                input tcb_pkg::ben_t b);
    tcb_pkg::dat_t res;
    res = old_w;
    for (int i = 0; i < `TCB_BEN_W; i++) begin
      if (b[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic tcb_pkg::dat_t rand_word();
    return $random(seed);
  endfunction

  // word n of the register page
  function automatic tcb_pkg::adr_t reg_adr(input int n);
    return {12'h100, n[1:0], 2'b00};
  endfunction

  // random word of page 0
  function automatic tcb_pkg::adr_t mem_adr(input tcb_pkg::dat_t r);
    return {4'h0, r[9:0], 2'b00};
  endfunction

  // expected response from the address map rules
  task automatic push_expected(input logic wr, input tcb_pkg::adr_t a,
                               input tcb_pkg::ben_t b, input tcb_pkg::dat_t d);
    tcb_pkg::dat_t r;
    logic          e;
    int            n;
    r = '0;
    e = 1'b0;
    n = int'(a[3:2]);
    if (a[15:12] == 4'h0) begin
      if (wr) begin
        ref_mem[a[11:2]] = merge_bytes(ref_mem[a[11:2]], d, b);
      end else begin
        r = ref_mem[a[11:2]];
      end
    end else if (a[15:4] == 12'h100) begin
      // identity word is read-only
      if (n == 0) begin
        if (wr) begin
          e = 1'b1;
        end else begin
          r = `TCB_REGS_ID;
        end
      end else if (wr) begin
        ref_regs[n] = merge_bytes(ref_regs[n], d, b);
      end else begin
        r = ref_regs[n];
      end
    end else begin
      e = 1'b1;
    end
    exp_rdt_q.push_back(r);
    exp_err_q.push_back(e);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus and test framing
  ////////////////////////////////////////////////////////////

  task automatic send_request(input logic wr, input tcb_pkg::adr_t a,
                              input tcb_pkg::ben_t b, input tcb_pkg::dat_t d);
    push_expected(wr, a, b, d);
    vld <= 1'b1;
    wen <= wr;
    adr <= a;
    ben <= b;
    wdt <= d;
    @(posedge clk);
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_at_start = errors + lost_rsp;
    tests++;
  endtask

  // drop vld and wait for the outstanding responses
  task automatic end_test();
    int n;
    n = 0;
    vld <= 1'b0;
    wen <= 1'b0;
    while (exp_rdt_q.size() != 0 && n < 4) begin
      @(posedge clk);
      n++;
    end
    if (exp_rdt_q.size() != 0) begin
      $display("test %s: %0d responses never arrived", cur_test, exp_rdt_q.size());
      lost_rsp++;
      exp_rdt_q.delete();
      exp_err_q.delete();
    end
    if (errors + lost_rsp == err_at_start) begin
      $display("test %s passed", cur_test);
    end else begin
      failed++;
      $display("test %s failed with %0d errors", cur_test,
               errors + lost_rsp - err_at_start);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
    $past(vld, `TCB_DLY) |-> rsp_vld)
    else begin
      $display("request before %0t got no response one cycle later", $time);
      errors++;
    end

  rsp_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_vld |-> $past(vld, `TCB_DLY))
    else begin
      $display("response at %0t without a request one cycle earlier", $time);
      errors++;
    end

  always @(posedge clk) begin : check_rsp
    tcb_pkg::dat_t e_rdt;
    logic          e_err;
    if (rst_n && rsp_vld) begin
      if (exp_rdt_q.size() == 0) begin
        $display("test %s: response arrived with no request outstanding", cur_test);
        errors++;
      end else begin
        e_rdt = exp_rdt_q.pop_front();
        e_err = exp_err_q.pop_front();
        checks++;
        rdt_ok: assert (rdt == e_rdt)
          else begin
            $display("mismatch test %s rdt expected %h actual %h", cur_test, e_rdt, rdt);
            errors++;
          end
        err_ok: assert (err == e_err)
          else begin
            $display("mismatch test %s err expected %0b actual %0b", cur_test, e_err, err);
            errors++;
          end
      end
    end
  end

  initial begin
    #(WATCHDOG_CYC * CLK_PERIOD);
    $display("watchdog expired before the tests completed");
    $display("ERRORS FOUND");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    tcb_pkg::dat_t r;
    tcb_pkg::adr_t a;
    rst_n = 1'b0;
    vld   = 1'b0;
    wen   = 1'b0;
    adr   = '0;
    ben   = '0;
    wdt   = '0;
    for (int n = 1; n < 4; n++) begin
      ref_regs[n] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    // full write, partial write, read back
    begin_test("mem_write_read");
    for (int i = 0; i < N_MEM; i++) begin
      r = rand_word();
      a = mem_adr(r);
      mem_adrs.push_back(a);
      send_request(1'b1, a, 4'hf, rand_word());
      r = rand_word();
      send_request(1'b1, a, r[3:0], rand_word());
      send_request(1'b0, a, 4'hf, '0);
    end
    end_test();

    begin_test("id_register");
    send_request(1'b0, reg_adr(0), 4'hf, '0);
    send_request(1'b1, reg_adr(0), 4'hf, rand_word());
    send_request(1'b0, reg_adr(0), 4'hf, '0);
    end_test();

    begin_test("scratch_registers");
    for (int n = 1; n < 4; n++) begin
      send_request(1'b0, reg_adr(n), 4'hf, '0);
    end
    for (int n = 1; n < 4; n++) begin
      send_request(1'b1, reg_adr(n), 4'b0101, rand_word());
      r = rand_word();
      send_request(1'b1, reg_adr(n), r[3:0], rand_word());
    end
    for (int n = 1; n < 4; n++) begin
      send_request(1'b0, reg_adr(n), 4'hf, '0);
    end
    end_test();

    // misses alias real words in their low bits
    begin_test("unmapped");
    for (int i = 0; i < N_MISS; i++) begin
      r = rand_word();
      if (i % 2 == 0) begin
        // page 1 miss that aliases a scratch word
        a = {4'h1, r[11:4] | 8'h01, r[3:2] | 2'b01, 2'b00};
      end else begin
        a = {r[15:12] | 4'h2, mem_adrs[0][11:0]};
      end
      send_request((i % 4) < 2, a, 4'hf, rand_word());
    end
    send_request(1'b0, mem_adrs[0], 4'hf, '0);
    for (int n = 1; n < 4; n++) begin
      send_request(1'b0, reg_adr(n), 4'hf, '0);
    end
    end_test();

    begin_test("back_to_back");
    for (int i = 0; i < N_B2B; i++) begin
      a = mem_adrs[i];
      send_request(1'b1, a, 4'hf, rand_word());
      send_request(1'b0, reg_adr(i % 4), 4'hf, '0);
      send_request(1'b0, a, 4'hf, '0);
      r = rand_word();
      send_request(1'b1, reg_adr(1 + i % 3), r[3:0], rand_word());
    end
    end_test();

    // memory word with the same index as the register read next
    begin_test("reg_after_mem");
    for (int i = 0; i < N_PRI; i++) begin
      a = reg_adr(1 + i % 3) & 16'h0fff;
      send_request(1'b1, a, 4'hf, rand_word());
      send_request(1'b0, reg_adr(1 + i % 3), 4'hf, '0);
    end
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed, checks, errors + lost_rsp);
    if (errors + lost_rsp == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule: tcb_lib_interconnect_tb

`default_nettype wire

//--- tcb_lib_interconnect.f
+incdir+.
tcb_pkg.sv
tcb_map_pkg.sv
tcb_lib_decoder.sv
tcb_lib_demultiplexer.sv
tcb_mem.sv
tcb_regs.sv
tcb_lib_interconnect.sv
tcb_lib_interconnect_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tcb_lib_interconnect_tb \
  -f tcb_lib_interconnect.f -o sim \
  && ./obj_dir/sim | tee sim.log \
  && test -s sim.log \
  && ! grep -q "ERRORS FOUND" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
